// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --timescale 1ns/100ps -Wno-fatal
TOP       ?= tb_fmc_led_init
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
PASS_MSG  := test passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// ==== bus_phase_tracker.sv ====
`default_nettype none

module bus_phase_tracker (
    input  wire logic CLK,
    input  wire logic delay_rst_reg,
    input  wire logic scl_filt_i,
    input  wire logic sda_filt_i,
    output logic      bus_free_o,
    output logic      data_slot_o,
    output logic      sample_slot_o,
    output logic      sda_sample_o
);

    import i2c_seq_pkg::*;

    // Previous filtered SCL for edge detection
    logic                  scl_q;
    // Direction of the edge that started the running hold count
    logic                  edge_rise_q;
    // Hold countdown, zero when idle
    logic [HOLD_CNT_W-1:0] hold_cnt_q;
    // Idle time of the bus, saturating
    logic [FREE_CNT_W-1:0] free_cnt_q;
    logic                  data_slot_q;
    logic                  sample_slot_q;
    logic                  sda_sample_q;
    logic                  scl_rise;
    logic                  scl_fall;
    logic                  hold_done;
    logic                  bus_idle;

    assign scl_rise  = scl_filt_i & ~scl_q;
    assign scl_fall  = ~scl_filt_i & scl_q;
    // The strobe register fires one cycle after this
    assign hold_done = hold_cnt_q == HOLD_CNT_W'(1);
    assign bus_idle  = scl_filt_i & sda_filt_i;

    assign data_slot_o   = data_slot_q;
    assign sample_slot_o = sample_slot_q;
    assign sda_sample_o  = sda_sample_q;
    assign bus_free_o    = free_cnt_q == FREE_CNT_W'(BUS_FREE_CYCLES);

    ////////////////////////////////////////////////////////////
    // SCL edge to strobe timing
    ////////////////////////////////////////////////////////////

    always_ff @(posedge CLK) begin
        if (delay_rst_reg) begin
            scl_q         <= 1'b1;
            edge_rise_q   <= 1'b0;
            hold_cnt_q    <= '0;
            data_slot_q   <= 1'b0;
            sample_slot_q <= 1'b0;
        end else begin
            scl_q         <= scl_filt_i;
            // Strobes are single-cycle
            data_slot_q   <= hold_done & ~edge_rise_q;
            sample_slot_q <= hold_done & edge_rise_q;
            if (scl_rise || scl_fall) begin
                // Count from the edge cycle so the strobe lands exactly
                // HOLD_CYCLES after the filtered edge
                hold_cnt_q  <= HOLD_CNT_W'(HOLD_CYCLES - 1);
                edge_rise_q <= scl_rise;
            end else if (hold_cnt_q != '0) begin
                hold_cnt_q <= hold_cnt_q - 1'b1;
            end
        end
    end

    // SDA is taken together with the sample strobe so both are
    // valid in the same cycle
    always_ff @(posedge CLK) begin
        if (hold_done && edge_rise_q) begin
            sda_sample_q <= sda_filt_i;
        end
    end

    ////////////////////////////////////////////////////////////
    // Bus free detection
    ////////////////////////////////////////////////////////////

    always_ff @(posedge CLK) begin
        if (delay_rst_reg) begin
            free_cnt_q <= '0;
        end else if (!bus_idle) begin
            // Any low level on either line restarts the idle time
            free_cnt_q <= '0;
        end else if (!bus_free_o) begin
            free_cnt_q <= free_cnt_q + 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== byte_shifter.sv ====
`default_nettype none

module byte_shifter (
    input  wire logic                   CLK,
    input  wire logic                   delay_rst_reg,
    input  wire logic                   load_i,
    input  wire i2c_seq_pkg::i2c_byte_u byte_i,
    input  wire logic                   shift_i,
    output logic                        tx_bit_o,
    output logic                        last_bit_o
);

    import i2c_seq_pkg::*;

    // Byte being sent, only its raw view is needed here
    i2c_byte_u  data_q;
    // Position of the bit on the line, 7 first
    logic [2:0] bit_cnt_q;

    assign tx_bit_o   = data_q.raw[bit_cnt_q];
    // Bit 0 is on the line, so the following clock carries the ACK
    assign last_bit_o = bit_cnt_q == 3'd0;

    always_ff @(posedge CLK) begin
        if (load_i) begin
            data_q <= byte_i;
        end
    end

    always_ff @(posedge CLK) begin
        if (delay_rst_reg) begin
            bit_cnt_q <= 3'd7;
        end else if (load_i) begin
            // MSB goes out first
            bit_cnt_q <= 3'd7;
        end else if (shift_i && !last_bit_o) begin
            bit_cnt_q <= bit_cnt_q - 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== fmc_led_init_top.sv ====
`default_nettype none

module fmc_led_init_top (
    input  wire logic CLK,
    input  wire logic delay_rst_reg,
    input  wire logic scl_i,
    input  wire logic sda_i,
    output logic      scl_oe_o,
    output logic      sda_oe_o,
    output logic      done_led_o
);

    import i2c_seq_pkg::*;

    // Filtered bus lines
    logic      scl_filt;
    logic      sda_filt;
    // Tracker status and strobes
    logic      bus_free;
    logic      data_slot;
    logic      sample_slot;
    logic      sda_sample;
    // Controller to generator and shifter
    logic      clk_en;
    logic      load;
    logic      shift;
    i2c_byte_u cmd_byte;
    // Shifter back to controller
    logic      tx_bit;
    logic      last_bit;

    line_filter #(.STAGES(FILTER_STAGES)) scl_filter_inst (
        .CLK(CLK), .delay_rst_reg(delay_rst_reg), .line_i(scl_i), .line_o(scl_filt)
    );

    line_filter #(.STAGES(FILTER_STAGES)) sda_filter_inst (
        .CLK(CLK), .delay_rst_reg(delay_rst_reg), .line_i(sda_i), .line_o(sda_filt)
    );

    scl_clock_gen scl_clock_gen_inst (
        .CLK(CLK), .delay_rst_reg(delay_rst_reg), .clk_en_i(clk_en), .scl_oe_o(scl_oe_o)
    );

    bus_phase_tracker bus_phase_tracker_inst (
        .CLK(CLK), .delay_rst_reg(delay_rst_reg),
        .scl_filt_i(scl_filt), .sda_filt_i(sda_filt),
        .bus_free_o(bus_free), .data_slot_o(data_slot),
        .sample_slot_o(sample_slot), .sda_sample_o(sda_sample)
    );

    byte_shifter byte_shifter_inst (
        .CLK(CLK), .delay_rst_reg(delay_rst_reg),
        .load_i(load), .byte_i(cmd_byte), .shift_i(shift),
        .tx_bit_o(tx_bit), .last_bit_o(last_bit)
    );

    i2c_seq_ctrl i2c_seq_ctrl_inst (
        .CLK(CLK), .delay_rst_reg(delay_rst_reg),
        .bus_free_i(bus_free), .data_slot_i(data_slot),
        .sample_slot_i(sample_slot), .sda_sample_i(sda_sample),
        .tx_bit_i(tx_bit), .last_bit_i(last_bit),
        .clk_en_o(clk_en), .load_o(load), .byte_o(cmd_byte), .shift_o(shift),
        .sda_oe_o(sda_oe_o), .done_led_o(done_led_o)
    );

endmodule

`default_nettype wire

// ==== i2c_seq_ctrl.sv ====
`default_nettype none

module i2c_seq_ctrl (
    input  wire logic                CLK,
    input  wire logic                delay_rst_reg,
    input  wire logic                bus_free_i,
    input  wire logic                data_slot_i,
    input  wire logic                sample_slot_i,
    input  wire logic                sda_sample_i,
    input  wire logic                tx_bit_i,
    input  wire logic                last_bit_i,
    output logic                     clk_en_o,
    output logic                     load_o,
    output i2c_seq_pkg::i2c_byte_u   byte_o,
    output logic                     shift_o,
    output logic                     sda_oe_o,
    output logic                     done_led_o
);

    import i2c_seq_pkg::*;

    logic [3:0] state_q;
    logic [3:0] state_d;
    byte_idx_t  idx_q;
    byte_idx_t  idx_d;
    byte_idx_t  idx_inc;
    // Target address of the transaction in progress
    logic [6:0] txn_addr_q;
    logic [6:0] txn_addr_d;
    logic       sda_oe_q;
    logic       sda_oe_d;
    logic       clk_en_q;
    logic       clk_en_d;
    logic       led_q;
    logic       led_d;

    // Find the list entry that opened the transaction with this address
    function automatic byte_idx_t rewind_idx(input logic [6:0] addr);
        byte_idx_t result;
        result = '0;
        for (int i = 0; i < NUM_BYTES; i++) begin
            if (ADDR_FRAME_MASK[i] && CMD_LIST[i].frame.addr == addr) begin
                result = byte_idx_t'(i);
            end
        end
        return result;
    endfunction

    assign idx_inc    = idx_q + 3'd1;
    // The shifter takes the entry the index is about to point at
    assign byte_o     = CMD_LIST[idx_d];
    assign clk_en_o   = clk_en_q;
    assign sda_oe_o   = sda_oe_q;
    assign done_led_o = led_q;

    ////////////////////////////////////////////////////////////
    // Next-state logic
    ////////////////////////////////////////////////////////////

    always_comb begin
        state_d    = state_q;
        idx_d      = idx_q;
        txn_addr_d = txn_addr_q;
        sda_oe_d   = sda_oe_q;
        clk_en_d   = clk_en_q;
        led_d      = led_q;
        load_o     = 1'b0;
        shift_o    = 1'b0;

        case (state_q)
            WAIT_FREE: begin
                if (bus_free_i) begin
                    state_d = START;
                end
            end
            START: begin
                // SDA falls with SCL released, the generator holds SCL
                // high for one more half before the first low
                sda_oe_d = 1'b1;
                clk_en_d = 1'b1;
                idx_d    = '0;
                load_o   = 1'b1;
                state_d  = SEND_BIT;
            end
            SEND_BIT: begin
                if (data_slot_i) begin
                    sda_oe_d = ~tx_bit_i;
                end else if (sample_slot_i) begin
                    // Step the shifter during SCL high, well before
                    // the next data slot
                    if (last_bit_i) begin
                        state_d = ACK_RELEASE;
                    end else begin
                        shift_o = 1'b1;
                    end
                end
            end
            ACK_RELEASE: begin
                // Hand SDA to the target for the ninth clock
                if (data_slot_i) begin
                    sda_oe_d = 1'b0;
                    state_d  = ACK_CHECK;
                end
            end
            ACK_CHECK: begin
                if (sample_slot_i) begin
                    if (sda_sample_i) begin
                        // NACK, resend the whole transaction
                        idx_d   = rewind_idx(txn_addr_q);
                        state_d = RESTART_HIGH;
                    end else if (idx_q == byte_idx_t'(NUM_BYTES - 1)) begin
                        state_d = STOP_LOW;
                    end else begin
                        idx_d = idx_inc;
                        if (ADDR_FRAME_MASK[idx_inc]) begin
                            state_d = RESTART_HIGH;
                        end else begin
                            load_o  = 1'b1;
                            state_d = SEND_BIT;
                        end
                    end
                end
            end
            RESTART_HIGH: begin
                // Release SDA while SCL is low
                if (data_slot_i) begin
                    sda_oe_d = 1'b0;
                    state_d  = RESTART_LOW;
                end
            end
            RESTART_LOW: begin
                // SDA falling during SCL high is the repeated START
                if (sample_slot_i) begin
                    sda_oe_d = 1'b1;
                    load_o   = 1'b1;
                    state_d  = SEND_BIT;
                end
            end
            STOP_LOW: begin
                if (data_slot_i) begin
                    sda_oe_d = 1'b1;
                    state_d  = STOP_HIGH;
                end
            end
            STOP_HIGH: begin
                // SDA rising during SCL high is the STOP, and SCL then
                // stays released at the end of this half
                if (sample_slot_i) begin
                    sda_oe_d = 1'b0;
                    clk_en_d = 1'b0;
                    led_d    = 1'b1;
                    state_d  = DONE;
                end
            end
            DONE: begin
                // Parked until reset with the LED on
                led_d = 1'b1;
            end
            default: begin
                state_d = WAIT_FREE;
            end
        endcase

        // Remember which transaction a freshly loaded address opens
        if (load_o && ADDR_FRAME_MASK[idx_d]) begin
            txn_addr_d = CMD_LIST[idx_d].frame.addr;
        end
    end

    ////////////////////////////////////////////////////////////
    // State registers
    ////////////////////////////////////////////////////////////

    always_ff @(posedge CLK) begin
        if (delay_rst_reg) begin
            state_q    <= WAIT_FREE;
            idx_q      <= '0;
            txn_addr_q <= '0;
            sda_oe_q   <= 1'b0;
            clk_en_q   <= 1'b0;
            led_q      <= 1'b0;
        end else begin
            state_q    <= state_d;
            idx_q      <= idx_d;
            txn_addr_q <= txn_addr_d;
            sda_oe_q   <= sda_oe_d;
            clk_en_q   <= clk_en_d;
            led_q      <= led_d;
        end
    end

endmodule

`default_nettype wire

// ==== i2c_seq_pkg.sv ====
`default_nettype none

package i2c_seq_pkg;

    ////////////////////////////////////////////////////////////
    // Bus timing, all counts in CLK cycles
    ////////////////////////////////////////////////////////////

    // Each SCL half lasts 5 us at 50 MHz, so the bus runs at 100 kHz
    localparam int SCL_HALF_CYCLES = 250;
    // Delay after an SCL edge before SDA moves or the ACK is sampled
    localparam int HOLD_CYCLES     = 12;
    // Both lines must sit high this long before the first START
    localparam int BUS_FREE_CYCLES = 64;
    // Synchronizer depth of each line filter
    localparam int FILTER_STAGES   = 2;

    // Counter widths derived from the timing above
    localparam int HALF_CNT_W = $clog2(SCL_HALF_CYCLES);
    localparam int HOLD_CNT_W = $clog2(HOLD_CYCLES);
    localparam int FREE_CNT_W = $clog2(BUS_FREE_CYCLES + 1);

    ////////////////////////////////////////////////////////////
    // Command list
    ////////////////////////////////////////////////////////////

    localparam int NUM_BYTES = 5;

    typedef logic [2:0] byte_idx_t;

    // First byte of a transaction: 7-bit target address, then R/W
    typedef struct packed {
        logic [6:0] addr;
        logic       rw;
    } i2c_addr_frame_t;

    // A list entry is either plain data or an address frame
    typedef union packed {
        logic [7:0]      raw;
        i2c_addr_frame_t frame;
    } i2c_byte_u;

    // Entry 0 is the rightmost: bus switch 0xE2, channel 0x80,
    // then logic device 0x7C, control register 0x02, LED value 0x01
    localparam i2c_byte_u [NUM_BYTES-1:0] CMD_LIST = {
        8'h01, 8'h02, 8'h7C, 8'h80, 8'hE2
    };

    // Entries that open a transaction
    localparam logic [NUM_BYTES-1:0] ADDR_FRAME_MASK = 5'b00101;

    ////////////////////////////////////////////////////////////
    // Controller FSM encodings
    ////////////////////////////////////////////////////////////

    localparam logic [3:0] WAIT_FREE    = 4'd0;
    localparam logic [3:0] START        = 4'd1;
    localparam logic [3:0] SEND_BIT     = 4'd2;
    localparam logic [3:0] ACK_RELEASE  = 4'd3;
    localparam logic [3:0] ACK_CHECK    = 4'd4;
    localparam logic [3:0] RESTART_HIGH = 4'd5;
    localparam logic [3:0] RESTART_LOW  = 4'd6;
    localparam logic [3:0] STOP_LOW     = 4'd7;
    localparam logic [3:0] STOP_HIGH    = 4'd8;
    localparam logic [3:0] DONE         = 4'd9;

endpackage

`default_nettype wire

// ==== i2c_target_model.sv ====
`default_nettype none

module i2c_target_model (
    input  wire logic scl_i,
    input  wire logic sda_i,
    output logic      sda_oe_o
);

    timeunit 1ns;
    timeprecision 100ps;

    // Kind of a log entry sits in bits 9:8, a received byte in bits 7:0
    localparam logic [1:0] EV_BYTE    = 2'd0;
    localparam logic [1:0] EV_START   = 2'd1;
    localparam logic [1:0] EV_RESTART = 2'd2;
    localparam logic [1:0] EV_STOP    = 2'd3;

    // Everything seen on the bus since the last clear
    logic [9:0] log_q[$];
    // Conditions that arrived after more than one SCL rise past an ACK
    int         frame_err = 0;
    // High between a START and its STOP
    logic       in_txn    = 1'b0;
    // SCL rises since the last condition or ACK, the ninth is the ACK clock
    int         bit_cnt   = 0;
    // Bytes received since the last clear
    int         byte_cnt  = 0;
    // Byte number to refuse once, negative when nothing is armed
    int         nack_at   = -1;
    logic [7:0] shift_q   = 8'h00;
    logic       ack_drive = 1'b0;

    assign sda_oe_o = ack_drive;

    task automatic clear_log();
        log_q.delete();
        frame_err = 0;
        in_txn    = 1'b0;
        bit_cnt   = 0;
        byte_cnt  = 0;
    endtask

    task automatic arm_nack(input int n);
        nack_at = n;
    endtask

    function automatic int log_size();
        return log_q.size();
    endfunction

    function automatic logic [9:0] log_entry(input int i);
        return log_q[i];
    endfunction

    ////////////////////////////////////////////////////////////
    // Bus conditions
    ////////////////////////////////////////////////////////////

    // SDA falling while SCL is high opens a transaction, or reopens one
    always @(negedge sda_i) begin
        if (scl_i === 1'b1) begin
            // Only the clock that carries the condition may precede it
            if (bit_cnt > 1) begin
                frame_err++;
            end
            log_q.push_back({in_txn ? EV_RESTART : EV_START, 8'h00});
            in_txn  = 1'b1;
            bit_cnt = 0;
        end
    end

    // SDA rising while SCL is high ends the transaction
    always @(posedge sda_i) begin
        if (scl_i === 1'b1) begin
            if (in_txn && bit_cnt > 1) begin
                frame_err++;
            end
            log_q.push_back({EV_STOP, 8'h00});
            in_txn  = 1'b0;
            bit_cnt = 0;
        end
    end

    ////////////////////////////////////////////////////////////
    // Data bits and ACK
    ////////////////////////////////////////////////////////////

    // Bits are taken on the rising SCL, MSB first
    always @(posedge scl_i) begin
        if (in_txn) begin
            bit_cnt++;
            if (bit_cnt <= 8) begin
                shift_q = {shift_q[6:0], sda_i};
            end
            if (bit_cnt == 8) begin
                log_q.push_back({EV_BYTE, shift_q});
            end
        end
    end

    // SDA only moves while SCL is low
    always @(negedge scl_i) begin
        if (in_txn) begin
            if (bit_cnt == 8) begin
                // Pull SDA low for the ACK unless this byte is to be refused
                ack_drive = (byte_cnt != nack_at);
                if (byte_cnt == nack_at) begin
                    nack_at = -1;
                end
                byte_cnt++;
            end else if (bit_cnt == 9) begin
                // The ACK clock is over, give SDA back to the master
                ack_drive = 1'b0;
                bit_cnt   = 0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== line_filter.sv ====
`default_nettype none

module line_filter #(
    parameter int STAGES = 2
) (
    input  wire logic CLK,
    input  wire logic delay_rst_reg,
    input  wire logic line_i,
    output logic      line_o
);

    // Synchronizer chain, newest sample in bit 0
    logic [STAGES-1:0] sync_q;
    // Last accepted line level
    logic              held_q;
    logic              agree;

    // The two oldest samples must match before the output may move
    assign agree  = sync_q[STAGES-1] == sync_q[STAGES-2];

    // A one-cycle glitch never shows up in both stages at once,
    // so the output keeps its previous level through it
    assign line_o = agree ? sync_q[STAGES-1] : held_q;

    always_ff @(posedge CLK) begin
        if (delay_rst_reg) begin
            // An idle I2C line floats high
            sync_q <= '1;
            held_q <= 1'b1;
        end else begin
            sync_q <= {sync_q[STAGES-2:0], line_i};
            held_q <= line_o;
        end
    end

endmodule

`default_nettype wire

// ==== scl_clock_gen.sv ====
`default_nettype none

module scl_clock_gen (
    input  wire logic CLK,
    input  wire logic delay_rst_reg,
    input  wire logic clk_en_i,
    output logic      scl_oe_o
);

    import i2c_seq_pkg::*;

    logic [HALF_CNT_W-1:0] half_cnt_q;
    // High while the generator is producing halves
    logic                  running_q;
    // High pulls SCL low
    logic                  scl_low_q;
    logic                  half_end;

    assign half_end = half_cnt_q == HALF_CNT_W'(SCL_HALF_CYCLES - 1);
    assign scl_oe_o = scl_low_q;

    always_ff @(posedge CLK) begin
        if (delay_rst_reg) begin
            half_cnt_q <= '0;
            running_q  <= 1'b0;
            scl_low_q  <= 1'b0;
        end else if (!running_q) begin
            // Idle with SCL released, the first half is a released one
            half_cnt_q <= '0;
            scl_low_q  <= 1'b0;
            if (clk_en_i) begin
                running_q <= 1'b1;
            end
        end else if (half_end) begin
            half_cnt_q <= '0;
            if (clk_en_i) begin
                scl_low_q <= ~scl_low_q;
            end else begin
                // Enable dropped, so stop only at a half boundary
                // and leave SCL released
                scl_low_q <= 1'b0;
                running_q <= 1'b0;
            end
        end else begin
            half_cnt_q <= half_cnt_q + 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== sources.f ====
i2c_seq_pkg.sv
line_filter.sv
scl_clock_gen.sv
bus_phase_tracker.sv
byte_shifter.sv
i2c_seq_ctrl.sv
fmc_led_init_top.sv
i2c_target_model.sv
tb_fmc_led_init.sv

// ==== tb_fmc_led_init.sv ====
`default_nettype none

module tb_fmc_led_init;

    timeunit 1ns;
    timeprecision 100ps;

    import i2c_seq_pkg::*;

    // Log entry kinds, matching the target model
    localparam logic [1:0] EV_BYTE    = 2'd0;
    localparam logic [1:0] EV_START   = 2'd1;
    localparam logic [1:0] EV_RESTART = 2'd2;
    localparam logic [1:0] EV_STOP    = 2'd3;

    localparam int NUM_TESTS = 5;
    // Every byte plus restarts and STOP at nine clocks each, three times over
    localparam int RUN_LIMIT_CYCLES = (NUM_BYTES + 3) * 9 * 2 * SCL_HALF_CYCLES * 3;
    localparam longint WATCHDOG_NS  = longint'(NUM_TESTS) * RUN_LIMIT_CYCLES * 4;
    // Byte number of 0x02 in the clean order E2 80 7C 02 01
    localparam int SECOND_TXN_NACK  = 3;
    localparam int BUSY_HOLD_CYCLES = 1000;

    logic       CLK;
    logic       delay_rst_reg;
    // Holds SDA low to simulate another master on the bus
    logic       hold_sda;
    logic       scl_oe;
    logic       sda_oe;
    logic       done_led;
    logic       tgt_sda_oe;
    logic       scl_line;
    logic       sda_line;
    logic [9:0] expect_q[$];
    int         checks       = 0;
    int         value_errors = 0;
    int         other_errors = 0;

    // Open-drain bus, any enable pulls the line low
    assign scl_line = ~scl_oe;
    assign sda_line = ~(sda_oe | tgt_sda_oe | hold_sda);

    fmc_led_init_top fmc_led_init_top_inst (
        .CLK(CLK), .delay_rst_reg(delay_rst_reg), .scl_i(scl_line), .sda_i(sda_line),
        .scl_oe_o(scl_oe), .sda_oe_o(sda_oe), .done_led_o(done_led)
    );

    i2c_target_model target_model_inst (
        .scl_i(scl_line), .sda_i(sda_line), .sda_oe_o(tgt_sda_oe)
    );

    initial begin
        CLK = 1'b0;
        forever #2 CLK = ~CLK;
    end

    ////////////////////////////////////////////////////////////
    // Compare and report helpers
    ////////////////////////////////////////////////////////////

    task automatic compare_bit(input logic got, input logic exp, input string name);
        checks++;
        if (got !== exp) begin
            value_errors++;
            $display("[ERROR] %0t %s: got %b, expected %b", $time, name, got, exp);
        end
    endtask

    task automatic compare_byte(input i2c_byte_u got, input i2c_byte_u exp, input string name);
        checks++;
        if (got.raw !== exp.raw) begin
            value_errors++;
            $display("[ERROR] %0t %s: got %h, expected %h", $time, name, got.raw, exp.raw);
        end
    endtask

    task automatic report_failure(input string what);
        other_errors++;
        $display("%0t %s", $time, what);
    endtask

    function automatic string event_name(input logic [1:0] kind);
        case (kind)
            EV_START:   return "START";
            EV_RESTART: return "repeated START";
            EV_STOP:    return "STOP";
            default:    return "byte";
        endcase
    endfunction

    ////////////////////////////////////////////////////////////
    // Sequence helpers
    ////////////////////////////////////////////////////////////

    task automatic reset_dut();
        @(negedge CLK);
        delay_rst_reg = 1'b1;
        repeat (2) @(negedge CLK);
        delay_rst_reg = 1'b0;
    endtask

    // Expected bus events for a run that refuses byte number nack_at once
    task automatic build_expected(input int nack_at);
        int i;
        int rx;
        int txn;
        bit first;
        expect_q.delete();
        expect_q.push_back({EV_START, 8'h00});
        i     = 0;
        rx    = 0;
        txn   = 0;
        first = 1'b1;
        while (i < NUM_BYTES) begin
            if (ADDR_FRAME_MASK[i]) begin
                txn = i;
                // Each transaction after the first opens with a repeated START
                if (!first) begin
                    expect_q.push_back({EV_RESTART, 8'h00});
                end
            end
            first = 1'b0;
            expect_q.push_back({EV_BYTE, CMD_LIST[i].raw});
            // A refused byte sends the master back to its transaction's address
            if (rx == nack_at) begin
                i = txn;
            end else begin
                i++;
            end
            rx++;
        end
        expect_q.push_back({EV_STOP, 8'h00});
    endtask

    task automatic check_log(input string label);
        int         n;
        logic [9:0] got;
        logic [9:0] exp;
        n = target_model_inst.log_size();
        if (n != expect_q.size()) begin
            report_failure($sformatf("%s: target saw %0d bus events instead of %0d",
                                     label, n, expect_q.size()));
        end
        if (n > expect_q.size()) begin
            n = expect_q.size();
        end
        for (int i = 0; i < n; i++) begin
            got = target_model_inst.log_entry(i);
            exp = expect_q[i];
            if (got[9:8] != exp[9:8]) begin
                report_failure($sformatf("%s: event %0d is a %s where a %s belongs", label,
                                         i, event_name(got[9:8]), event_name(exp[9:8])));
            end else if (exp[9:8] == EV_BYTE) begin
                compare_byte(got[7:0], exp[7:0], $sformatf("%s byte event %0d", label, i));
            end
        end
        // Conditions inside a byte mean a missing or extra ACK clock
        if (target_model_inst.frame_err != 0) begin
            report_failure($sformatf("%s: %0d bus conditions arrived in the middle of a byte",
                                     label, target_model_inst.frame_err));
        end
    endtask

    task automatic wait_for_led();
        int cycles;
        cycles = 0;
        while (done_led !== 1'b1 && cycles < RUN_LIMIT_CYCLES) begin
            @(negedge CLK);
            cycles++;
        end
        if (done_led !== 1'b1) begin
            report_failure($sformatf("done_led_o did not rise within %0d cycles",
                                     RUN_LIMIT_CYCLES));
        end
    endtask

    task automatic run_sequence(input int nack_at, input string label);
        target_model_inst.clear_log();
        target_model_inst.arm_nack(nack_at);
        wait_for_led();
        // The STOP lands with the LED, a few cycles let the bus settle
        repeat (8) @(negedge CLK);
        build_expected(nack_at);
        check_log(label);
    endtask

    ////////////////////////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////////////////////////

    task automatic test_reset_state();
        reset_dut();
        // The bus cannot be seen as free for BUS_FREE_CYCLES yet
        repeat (BUS_FREE_CYCLES / 2) begin
            @(negedge CLK);
            compare_bit(scl_oe, 1'b0, "scl_oe_o");
            compare_bit(sda_oe, 1'b0, "sda_oe_o");
            compare_bit(done_led, 1'b0, "done_led_o");
        end
    endtask

    task automatic test_clean_run();
        reset_dut();
        run_sequence(-1, "clean run");
        repeat (1000) begin
            @(negedge CLK);
            compare_bit(done_led, 1'b1, "done_led_o");
        end
        compare_bit(scl_oe, 1'b0, "scl_oe_o");
        compare_bit(sda_oe, 1'b0, "sda_oe_o");
    endtask

    task automatic test_retry_second();
        reset_dut();
        run_sequence(SECOND_TXN_NACK, "retry second transaction");
        compare_bit(done_led, 1'b1, "done_led_o");
    endtask

    task automatic test_retry_first();
        int pick;
        // Refuse either the bus-switch address or its channel byte
        pick = int'($urandom % 2);
        $display("refusing byte %0d of the first transaction", pick);
        reset_dut();
        run_sequence(pick, "retry first transaction");
        compare_bit(done_led, 1'b1, "done_led_o");
    endtask

    task automatic test_busy_bus();
        @(negedge CLK);
        hold_sda = 1'b1;
        reset_dut();
        repeat (BUSY_HOLD_CYCLES) begin
            @(negedge CLK);
            compare_bit(scl_oe, 1'b0, "scl_oe_o");
            compare_bit(sda_oe, 1'b0, "sda_oe_o");
        end
        hold_sda = 1'b0;
        // Let the model see the release before its log is cleared
        @(negedge CLK);
        run_sequence(-1, "busy bus");
        compare_bit(done_led, 1'b1, "done_led_o");
    endtask

    ////////////////////////////////////////////////////////////
    // Main sequence and watchdog
    ////////////////////////////////////////////////////////////

    initial begin
        int unsigned seed;
        delay_rst_reg = 1'b1;
        hold_sda      = 1'b0;
        seed          = 32'h4cd3;
        void'($urandom(seed));
        test_reset_state();
        test_clean_run();
        test_retry_second();
        test_retry_first();
        test_busy_bus();
        $display("checks %0d, value errors %0d, other failures %0d",
                 checks, value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns with tests still running", WATCHDOG_NS);
        $display("test failed");
        $finish;
    end

endmodule

`default_nettype wire
